/* Bender.yml */
package:
  name: pha_spectrometer

sources:
  - files:
      - verilog/pha_sample_pkg.sv
      - verilog/pha_hist_pkg.sv
      - verilog/pulse_height_analyzer.sv
      - verilog/bin_mapper.sv
      - verilog/histogram_accumulator.sv
      - verilog/pha_spectrometer.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/pha_spectrometer_tb.sv

/* compile.f */
+incdir+sim
verilog/pha_sample_pkg.sv
verilog/pha_hist_pkg.sv
verilog/pulse_height_analyzer.sv
verilog/bin_mapper.sv
verilog/histogram_accumulator.sv
verilog/pha_spectrometer.sv
sim/pha_spectrometer_tb.sv

/* sim/pha_tb_tasks.svh */
`ifndef PHA_TB_TASKS_SVH
`define PHA_TB_TASKS_SVH

// a full-scale spike opens a dead window, so the step to a new baseline cannot arm.
task automatic drive_pulse(input int baseline, input int height, input bit settle, input int tail);
  int steps;
  int k;
  steps = (height >= 4) ? 4 : 1;
  if (settle)
  begin
    send_sample(16'hffff);
    send_sample(16'hffff);
    repeat (DEAD_TIME + 2) send_sample(baseline);
  end
  else
  begin
    repeat (2) send_sample(baseline);
  end
  for (k = 1; k <= steps; k++)
  begin
    send_sample(baseline + height * k / steps);
  end
  for (k = steps - 1; k >= 0; k--)
  begin
    send_sample(baseline + height * k / steps);
  end
  repeat (tail) send_sample(baseline);
  s_sample_valid = 1'b0;
endtask

task automatic clear_and_sweep();
  int addr;
  clear_histogram();
  checks++;
  assert (busy_cycles == NUM_BINS)
  else
  begin
    value_errors++;
    $display("ERR %0t busy cycles: got %0d, expected %0d", $time, busy_cycles, NUM_BINS);
  end
  for (addr = 0; addr < NUM_BINS; addr++)
  begin
    check_bin(addr);
  end
endtask

task automatic single_pulses();
  int baseline;
  int height;
  cfg_shift      = '0;
  cfg_min_height = '0;
  cfg_max_peak   = 16'hfff0;
  repeat (6)
  begin
    clear_histogram();
    baseline = random_bits(8);
    height   = 16 + random_bits(9);
    drive_pulse(baseline, height, 1'b1, DEAD_TIME + 2);
    predict_pulse(baseline, height);
    check_neighbors(height);
  end
endtask

task automatic cutoff_limits();
  int baseline;
  cfg_shift      = '0;
  cfg_min_height = 16'd100;
  cfg_max_peak   = 16'd1000;
  clear_histogram();
  baseline = random_bits(8);
  drive_pulse(baseline, 100, 1'b1, DEAD_TIME + 2);
  predict_pulse(baseline, 100);
  drive_pulse(700, 300, 1'b1, DEAD_TIME + 2);
  predict_pulse(700, 300);
  // height 101 and peak 999 lie just inside the limits.
  drive_pulse(898, 101, 1'b1, DEAD_TIME + 2);
  predict_pulse(898, 101);
  check_bin(100);
  check_bin(300);
  check_bin(101);
endtask

task automatic gain_shift_and_overflow();
  int baseline;
  int height;
  cfg_shift      = 4'd2;
  cfg_min_height = '0;
  cfg_max_peak   = 16'hfff0;
  clear_histogram();
  repeat (3)
  begin
    baseline = random_bits(8);
    height   = 16 + random_bits(11);
    drive_pulse(baseline, height, 1'b1, DEAD_TIME + 2);
    predict_pulse(baseline, height);
    check_bin(height >> 2);
  end
  cfg_shift = '0;
  repeat (3)
  begin
    baseline = random_bits(8);
    height   = NUM_BINS + random_bits(10);
    drive_pulse(baseline, height, 1'b1, DEAD_TIME + 2);
    predict_pulse(baseline, height);
    check_overflow();
    check_bin(height % NUM_BINS);
  end
endtask

task automatic repeated_pulses();
  int baseline;
  int height;
  int k;
  cfg_shift      = '0;
  cfg_min_height = '0;
  cfg_max_peak   = 16'hfff0;
  clear_histogram();
  baseline = random_bits(8);
  height   = 16 + random_bits(9);
  // the first two events are held upstream by a clear and reach the memory back to back.
  clear = 1'b1;
  @(negedge aclk);
  clear = 1'b0;
  for (k = 0; k < 2; k++)
  begin
    drive_pulse(baseline, height, k == 0, DEAD_TIME + 2);
    predict_pulse(baseline, height);
  end
  wait_until_idle();
  for (k = 2; k < 8; k++)
  begin
    drive_pulse(baseline, height, 1'b0, DEAD_TIME + 2);
    predict_pulse(baseline, height);
  end
  check_neighbors(height);
endtask

task automatic dead_time_window();
  int baseline;
  cfg_shift      = '0;
  cfg_min_height = '0;
  cfg_max_peak   = 16'hfff0;
  clear_histogram();
  baseline = random_bits(8);
  drive_pulse(baseline, 40, 1'b1, 2);
  predict_pulse(baseline, 40);
  // rises seven samples after the event, inside the dead window.
  drive_pulse(baseline, 80, 1'b0, DEAD_TIME + 2);
  drive_pulse(baseline, 80, 1'b0, DEAD_TIME + 2);
  predict_pulse(baseline, 80);
  check_bin(40);
  check_bin(80);
endtask

`endif

/* sim/pha_spectrometer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pha_spectrometer_tb;
  import pha_sample_pkg::*;
  import pha_hist_pkg::*;

  localparam int DEAD_WIDTH    = 16;
  localparam int BIN_BITS      = 10;
  localparam int NUM_BINS      = 2 ** BIN_BITS;
  localparam int DEAD_TIME     = 8;
  localparam int CLEAR_TIMEOUT = 2 * NUM_BINS + 16;
  localparam int POLL_TIMEOUT  = 64;

  logic                  aclk;
  logic                  aresetn;
  logic                  s_sample_valid;
  sample_t               s_sample;
  logic                  s_sample_ready;
  logic [DEAD_WIDTH-1:0] cfg_dead_time;
  height_t               cfg_min_height;
  sample_t               cfg_max_peak;
  shift_t                cfg_shift;
  logic                  clear;
  logic                  busy;
  logic [BIN_BITS-1:0]   rd_addr;
  count_t                rd_data;
  count_t                overflow_count;

  // expected histogram and overflow total.
  count_t                model [NUM_BINS];
  count_t                exp_overflow;
  logic [15:0]           lfsr_q;
  int                    busy_cycles;
  int                    checks;
  int                    value_errors;
  int                    other_errors;

  pha_spectrometer #(
    .SIGNED_DATA (1'b0),
    .DEAD_WIDTH  (DEAD_WIDTH),
    .BIN_BITS    (BIN_BITS)
  ) dut (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .s_sample_valid (s_sample_valid),
    .s_sample       (s_sample),
    .s_sample_ready (s_sample_ready),
    .cfg_dead_time  (cfg_dead_time),
    .cfg_min_height (cfg_min_height),
    .cfg_max_peak   (cfg_max_peak),
    .cfg_shift      (cfg_shift),
    .clear          (clear),
    .busy           (busy),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .overflow_count (overflow_count)
  );

  initial
  begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  function automatic int random_bits(input int n);
    int value;
    int i;
    value = 0;
    for (i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = (value << 1) | lfsr_q[0];
    end
    return value;
  endfunction

  task automatic send_sample(input int value);
    int waited;
    s_sample_valid = 1'b1;
    s_sample       = value[15:0];
    waited         = 0;
    while (!s_sample_ready && waited < POLL_TIMEOUT)
    begin
      @(negedge aclk);
      waited++;
    end
    assert (s_sample_ready)
    else
    begin
      other_errors++;
      $display("sample input never became ready at %0t", $time);
    end
    // taken on the rising edge in between.
    @(negedge aclk);
  endtask

  task automatic wait_until_idle();
    busy_cycles = 0;
    while (busy && busy_cycles < CLEAR_TIMEOUT)
    begin
      @(negedge aclk);
      busy_cycles++;
    end
    assert (!busy)
    else
    begin
      other_errors++;
      $display("clear did not finish, busy stayed high at %0t", $time);
    end
  endtask

  task automatic clear_histogram();
    clear = 1'b1;
    @(negedge aclk);
    clear = 1'b0;
    wait_until_idle();
    foreach (model[i])
    begin
      model[i] = '0;
    end
  endtask

  task automatic predict_pulse(input int baseline, input int height);
    int bin;
    bin = height >> cfg_shift;
    if (height > cfg_min_height && baseline + height < cfg_max_peak)
    begin
      if (bin >= NUM_BINS)
      begin
        exp_overflow++;
      end
      else
      begin
        model[bin]++;
      end
    end
  endtask

  task automatic check_bin(input int addr);
    int waited;
    rd_addr = addr[BIN_BITS-1:0];
    waited  = 0;
    do
    begin
      @(negedge aclk);
      waited++;
    end
    while (rd_data !== model[addr] && waited < POLL_TIMEOUT);
    checks++;
    assert (rd_data === model[addr])
    else
    begin
      value_errors++;
      $display("ERR %0t rd_data[%0d]: got %0d, expected %0d", $time, addr, rd_data, model[addr]);
    end
  endtask

  task automatic check_neighbors(input int center);
    int addr;
    for (addr = center - 1; addr <= center + 1; addr++)
    begin
      if (addr >= 0 && addr < NUM_BINS)
      begin
        check_bin(addr);
      end
    end
  endtask

  task automatic check_overflow();
    int waited;
    waited = 0;
    while (overflow_count !== exp_overflow && waited < POLL_TIMEOUT)
    begin
      @(negedge aclk);
      waited++;
    end
    checks++;
    assert (overflow_count === exp_overflow)
    else
    begin
      value_errors++;
      $display("ERR %0t overflow_count: got %0d, expected %0d", $time, overflow_count,
               exp_overflow);
    end
  endtask

  `include "pha_tb_tasks.svh"

  initial
  begin
    aresetn        = 1'b0;
    s_sample_valid = 1'b0;
    s_sample       = '0;
    cfg_dead_time  = DEAD_TIME;
    cfg_min_height = '0;
    cfg_max_peak   = 16'hfff0;
    cfg_shift      = '0;
    clear          = 1'b0;
    rd_addr        = '0;
    lfsr_q         = 16'd42;
    exp_overflow   = '0;
    checks         = 0;
    value_errors   = 0;
    other_errors   = 0;
    repeat (10) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    clear_and_sweep();
    single_pulses();
    cutoff_limits();
    gain_shift_and_overflow();
    repeated_pulses();
    dead_time_window();

    $display("checks %0d, value errors %0d, other errors %0d", checks, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/bin_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module bin_mapper #(
  parameter int BIN_BITS = 10
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  pha_sample_pkg::shift_t  cfg_shift,
  input  logic                    height_valid,
  input  pha_sample_pkg::height_t height,
  output logic                    height_ready,
  output logic                    bin_valid,
  output logic [BIN_BITS-1:0]     bin,
  input  logic                    bin_ready,
  output pha_hist_pkg::count_t    overflow_count
);
  import pha_sample_pkg::*;

  height_t             scaled;
  logic                fits;
  logic                accept;
  logic                valid_q;
  logic [BIN_BITS-1:0] bin_q;

  assign scaled       = height >> cfg_shift;
  assign fits         = (scaled >> BIN_BITS) == '0;
  assign height_ready = ~valid_q | bin_ready;
  assign accept       = height_valid & height_ready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      valid_q        <= 1'b0;
      overflow_count <= '0;
    end
    else
    begin
      if (accept && fits)
      begin
        valid_q <= 1'b1;
      end
      else if (bin_ready)
      begin
        valid_q <= 1'b0;
      end

      // heights above the top bin are consumed here and only counted.
      if (accept && !fits && overflow_count != '1)
      begin
        overflow_count <= overflow_count + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept && fits)
    begin
      bin_q <= scaled[BIN_BITS-1:0];
    end
  end

  assign bin_valid = valid_q;
  assign bin       = bin_q;

endmodule

`default_nettype wire

/* verilog/histogram_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module histogram_accumulator #(
  parameter int BIN_BITS = 10
) (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 bin_valid,
  input  logic [BIN_BITS-1:0]  bin,
  output logic                 bin_ready,
  input  logic                 clear,
  output logic                 busy,
  input  logic [BIN_BITS-1:0]  rd_addr,
  output pha_hist_pkg::count_t rd_data
);
  import pha_hist_pkg::*;

  localparam int DEPTH = 2 ** BIN_BITS;

  count_t              mem [DEPTH];

  acc_state_t          state_q;
  logic [BIN_BITS-1:0] clr_addr_q;

  // read stage.
  logic                rd_valid_q;
  logic [BIN_BITS-1:0] rd_bin_q;

  // write stage.
  logic                wr_valid_q;
  logic [BIN_BITS-1:0] wr_bin_q;
  count_t              old_q;

  // copy of the previous write, for a same-bin event right behind it.
  logic                last_valid_q;
  logic [BIN_BITS-1:0] last_bin_q;
  count_t              last_cnt_q;

  logic                accept;
  count_t              base;
  count_t              next_cnt;
  logic                mem_we;
  logic [BIN_BITS-1:0] mem_addr;
  count_t              mem_wdata;

  assign bin_ready = (state_q == ACC_RUN);
  assign busy      = (state_q == ACC_CLEARING);
  assign accept    = bin_valid & bin_ready;

  // the memory read of the following event misses the write made on the same edge.
  assign base     = (last_valid_q && last_bin_q == wr_bin_q) ? last_cnt_q : old_q;
  assign next_cnt = (base == '1) ? base : base + 1'b1;

  always_comb
  begin
    if (state_q == ACC_CLEARING)
    begin
      mem_we    = 1'b1;
      mem_addr  = clr_addr_q;
      mem_wdata = '0;
    end
    else
    begin
      mem_we    = wr_valid_q;
      mem_addr  = wr_bin_q;
      mem_wdata = next_cnt;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_q      <= ACC_RUN;
      clr_addr_q   <= '0;
      rd_valid_q   <= 1'b0;
      wr_valid_q   <= 1'b0;
      last_valid_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        ACC_RUN:
        begin
          if (clear)
          begin
            state_q    <= ACC_CLEARING;
            clr_addr_q <= '0;
          end
        end
        ACC_CLEARING:
        begin
          clr_addr_q <= clr_addr_q + 1'b1;
          if (&clr_addr_q)
          begin
            state_q <= ACC_RUN;
          end
        end
        default:
        begin
          state_q <= ACC_RUN;
        end
      endcase

      // events still in the pipe are flushed by a clear.
      rd_valid_q   <= accept & ~clear;
      wr_valid_q   <= rd_valid_q & ~clear;
      last_valid_q <= wr_valid_q & (state_q == ACC_RUN);
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept)
    begin
      rd_bin_q <= bin;
    end
    wr_bin_q   <= rd_bin_q;
    last_bin_q <= wr_bin_q;
    last_cnt_q <= next_cnt;
  end

  always_ff @(posedge aclk)
  begin
    if (mem_we)
    begin
      mem[mem_addr] <= mem_wdata;
    end
    old_q   <= mem[rd_bin_q];
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* verilog/pha_hist_pkg.sv */
`default_nettype none

package pha_hist_pkg;

  // width of one histogram bin.
  localparam int COUNT_WIDTH = 32;

  // one bin count, saturating at all ones.
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // accumulator modes.
  // run counts incoming events, clearing zeroes the memory one word per cycle.
  typedef enum logic
  {
    ACC_RUN,
    ACC_CLEARING
  } acc_state_t;

endpackage

`default_nettype wire

/* verilog/pha_sample_pkg.sv */
`default_nettype none

package pha_sample_pkg;

  // width of the digitized detector signal.
  localparam int SAMPLE_WIDTH = 16;

  // width of the gain shift control.
  localparam int SHIFT_WIDTH = 4;

  // one ADC sample, also used for the peak cutoff.
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // peak sample minus the starting minimum.
  typedef logic [SAMPLE_WIDTH-1:0] height_t;

  // right shift applied to a height to get its bin.
  typedef logic [SHIFT_WIDTH-1:0] shift_t;

endpackage

`default_nettype wire

/* verilog/pha_spectrometer.sv */
`timescale 1ns/1ps
`default_nettype none

module pha_spectrometer #(
  parameter bit SIGNED_DATA = 1'b0,
  parameter int DEAD_WIDTH  = 16,
  parameter int BIN_BITS    = 10
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    s_sample_valid,
  input  pha_sample_pkg::sample_t s_sample,
  output logic                    s_sample_ready,
  input  logic [DEAD_WIDTH-1:0]   cfg_dead_time,
  input  pha_sample_pkg::height_t cfg_min_height,
  input  pha_sample_pkg::sample_t cfg_max_peak,
  input  pha_sample_pkg::shift_t  cfg_shift,
  input  logic                    clear,
  output logic                    busy,
  input  logic [BIN_BITS-1:0]     rd_addr,
  output pha_hist_pkg::count_t    rd_data,
  output pha_hist_pkg::count_t    overflow_count
);
  import pha_sample_pkg::*;

  logic                height_valid;
  height_t             height;
  logic                height_ready;
  logic                bin_valid;
  logic [BIN_BITS-1:0] bin;
  logic                bin_ready;

  pulse_height_analyzer #(
    .SIGNED_DATA (SIGNED_DATA),
    .DEAD_WIDTH  (DEAD_WIDTH)
  ) u_analyzer (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .s_sample_valid (s_sample_valid),
    .s_sample       (s_sample),
    .s_sample_ready (s_sample_ready),
    .cfg_dead_time  (cfg_dead_time),
    .cfg_min_height (cfg_min_height),
    .cfg_max_peak   (cfg_max_peak),
    .height_valid   (height_valid),
    .height         (height),
    .height_ready   (height_ready)
  );

  bin_mapper #(
    .BIN_BITS (BIN_BITS)
  ) u_mapper (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .cfg_shift      (cfg_shift),
    .height_valid   (height_valid),
    .height         (height),
    .height_ready   (height_ready),
    .bin_valid      (bin_valid),
    .bin            (bin),
    .bin_ready      (bin_ready),
    .overflow_count (overflow_count)
  );

  histogram_accumulator #(
    .BIN_BITS (BIN_BITS)
  ) u_accumulator (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .bin_valid (bin_valid),
    .bin       (bin),
    .bin_ready (bin_ready),
    .clear     (clear),
    .busy      (busy),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

/* verilog/pulse_height_analyzer.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_height_analyzer #(
  parameter bit SIGNED_DATA = 1'b0,
  parameter int DEAD_WIDTH  = 16
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    s_sample_valid,
  input  pha_sample_pkg::sample_t s_sample,
  output logic                    s_sample_ready,
  input  logic [DEAD_WIDTH-1:0]   cfg_dead_time,
  input  pha_sample_pkg::height_t cfg_min_height,
  input  pha_sample_pkg::sample_t cfg_max_peak,
  output logic                    height_valid,
  output pha_sample_pkg::height_t height,
  input  logic                    height_ready
);
  import pha_sample_pkg::*;

  // newest accepted sample.
  sample_t               last_q;
  sample_t               min_q;
  height_t               height_q;
  logic [DEAD_WIDTH-1:0] dead_cnt_q;
  logic                  rising_q;
  logic                  armed_q;
  logic                  valid_q;

  logic                  rising;
  logic                  peak_ok;
  height_t               diff;
  logic                  take;
  logic                  dead_done;
  logic                  arm;
  logic                  fall;
  logic                  fire;

  generate
    if (SIGNED_DATA)
    begin : g_signed
      assign rising  = $signed(last_q) < $signed(s_sample);
      assign peak_ok = $signed(last_q) < $signed(cfg_max_peak);
    end
    else
    begin : g_unsigned
      assign rising  = last_q < s_sample;
      assign peak_ok = last_q < cfg_max_peak;
    end
  endgenerate

  // a height is a magnitude, so it is compared unsigned in both modes.
  assign diff      = last_q - min_q;
  assign take      = s_sample_valid & s_sample_ready;
  assign dead_done = dead_cnt_q >= cfg_dead_time;
  assign arm       = take & dead_done & ~armed_q & ~rising_q & rising;
  assign fall      = take & armed_q & rising_q & ~rising;
  assign fire      = fall & (diff > cfg_min_height);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      last_q     <= '0;
      rising_q   <= 1'b0;
      armed_q    <= 1'b0;
      // no dead time before the first event.
      dead_cnt_q <= '1;
      valid_q    <= 1'b0;
    end
    else
    begin
      if (take)
      begin
        last_q   <= s_sample;
        rising_q <= rising;
      end

      if (fire)
      begin
        dead_cnt_q <= '0;
      end
      else if (take && !dead_done)
      begin
        dead_cnt_q <= dead_cnt_q + 1'b1;
      end

      // each pulse is judged once, at its first falling sample.
      if (arm)
      begin
        armed_q <= 1'b1;
      end
      else if (fall)
      begin
        armed_q <= 1'b0;
      end

      if (fire && peak_ok)
      begin
        valid_q <= 1'b1;
      end
      else if (height_ready)
      begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    // the sample before the rise is the local minimum.
    if (arm)
    begin
      min_q <= last_q;
    end
    // a newer event replaces one that is still waiting.
    if (fire && peak_ok)
    begin
      height_q <= diff;
    end
  end

  assign s_sample_ready = 1'b1;
  assign height_valid   = valid_q;
  assign height         = height_q;

endmodule

`default_nettype wire
